// File: mult_8.f
verilog/mult_cfg_pkg.sv
verilog/mult_types_pkg.sv
verilog/mult_bit_sequencer.sv
verilog/mult_add_shift.sv
verilog/mult_product_assembler.sv
verilog/mult_8.sv
dv/mult_8_assert.sv
dv/mult_8_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build mult_8_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 \
		--top-module mult_8_tb -Mdir obj_dir -f mult_8.f
	-./obj_dir/Vmult_8_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification passed" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: dv/mult_8_tb.sv
`timescale 1ns/1ps

module mult_8_tb
   import mult_cfg_pkg::*;
   import mult_types_pkg::*;
();

   localparam int half_period  = 20;
   localparam int reset_cycles = 10;
   localparam int wait_limit   = 40;
   localparam int random_runs  = 200;

   // edges to done, counting the edge that samples start as the first.
   localparam int done_edges = step_count + 1;

   logic     clk;
   logic     rst_n;
   logic     start;
   operand_t multiplier;
   operand_t multiplicand;
   logic     busy;
   logic     done;
   operand_t product_lo;
   operand_t product_hi;

   // expected products and their test names in launch order.
   logic [15:0] exp_q[$];
   string       name_q[$];

   int checked_count = 0;
   int check_count   = 0;
   int cmp_errors    = 0;
   int tb_errors     = 0;
   int test_count    = 0;
   int failed_tests  = 0;

   logic [15:0] cmp_expected;
   logic [15:0] cmp_actual;
   string       cmp_name;

   mult_8 uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .start        (start),
      .multiplier   (multiplier),
      .multiplicand (multiplicand),
      .busy         (busy),
      .done         (done),
      .product_lo   (product_lo),
      .product_hi   (product_hi)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #half_period clk = ~clk;
      end
   end

   // plain unsigned product of the two bytes.
   function automatic logic [15:0] ref_product(input operand_t a, input operand_t b);
      return 16'(a) * 16'(b);
   endfunction

   function automatic int total_errors();
      return cmp_errors + tb_errors;
   endfunction

   // compare each done against the oldest pending product.
   always @(posedge clk) begin
      if (rst_n && done) begin
         if (exp_q.size() == 0) begin
            $display("ERROR: done pulsed with no product pending");
            cmp_errors++;
         end else begin
            cmp_expected = exp_q.pop_front();
            cmp_name     = name_q.pop_front();
            cmp_actual   = {product_hi, product_lo};
            check_count++;
            if (cmp_actual !== cmp_expected) begin
               $display("FAIL %s: expected 16'h%04h, actual 16'h%04h",
                        cmp_name, cmp_expected, cmp_actual);
               cmp_errors++;
            end
         end
         checked_count++;
      end
   end

   task automatic launch_product(input string name, input operand_t a, input operand_t b);
      exp_q.push_back(ref_product(a, b));
      name_q.push_back(name);
      @(posedge clk);
      start        <= 1'b1;
      multiplier   <= a;
      multiplicand <= b;
      @(posedge clk);
      start <= 1'b0;
   endtask

   task automatic wait_checked(input int target, input string name);
      int cycles;
      cycles = 0;
      while (checked_count < target && cycles < wait_limit) begin
         @(negedge clk);
         cycles++;
      end
      if (checked_count < target) begin
         $display("ERROR: %s: done never arrived within %0d cycles", name, wait_limit);
         tb_errors++;
      end
   endtask

   task automatic run_product(input string name, input operand_t a, input operand_t b);
      int target;
      target = checked_count + 1;
      launch_product(name, a, b);
      wait_checked(target, name);
   endtask

   task automatic check_idle_zero(input string name);
      if (busy !== 1'b0 || done !== 1'b0) begin
         $display("ERROR: %s: busy or done not low after reset", name);
         tb_errors++;
      end
      if ({product_hi, product_lo} !== 16'h0000) begin
         $display("FAIL %s: expected 16'h0000, actual 16'h%04h",
                  name, {product_hi, product_lo});
         tb_errors++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      int errs;
      errs = total_errors() - errs_before;
      test_count++;
      if (errs == 0) begin
         $display("test %s: passed", name);
      end else begin
         $display("test %s: failed with %0d error(s)", name, errs);
         failed_tests++;
      end
   endtask

   task automatic test_reset_state();
      int errs_before;
      errs_before = total_errors();
      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_idle_zero("reset_state");
      finish_test("reset_state", errs_before);
   endtask

   task automatic test_corner_values();
      int errs_before;
      errs_before = total_errors();
      run_product("corner 0x0", 8'd0, 8'd0);
      run_product("corner 0x255", 8'd0, 8'd255);
      run_product("corner 1x255", 8'd1, 8'd255);
      run_product("corner 255x255", 8'd255, 8'd255);
      run_product("corner 128x2", 8'd128, 8'd2);
      finish_test("corner_values", errs_before);
   endtask

   task automatic test_random_operands();
      int       errs_before;
      operand_t a;
      operand_t b;
      errs_before = total_errors();
      for (int i = 0; i < random_runs; i++) begin
         a = operand_t'($urandom);
         b = operand_t'($urandom);
         run_product($sformatf("random %0d: %0d x %0d", i, a, b), a, b);
      end
      finish_test("random_operands", errs_before);
   endtask

   task automatic test_start_while_busy();
      int errs_before;
      int target;
      errs_before = total_errors();
      target      = checked_count + 1;
      launch_product("busy first pair", 8'd23, 8'd171);
      repeat (2) @(posedge clk);
      @(negedge clk);
      if (!busy) begin
         $display("ERROR: start_while_busy: busy was low while a product ran");
         tb_errors++;
      end
      // a second request with other operands must be dropped.
      @(posedge clk);
      start        <= 1'b1;
      multiplier   <= 8'd200;
      multiplicand <= 8'd99;
      @(posedge clk);
      start <= 1'b0;
      wait_checked(target, "busy first pair");
      repeat (2 * done_edges) @(negedge clk);
      if (checked_count != target) begin
         $display("ERROR: start_while_busy: an extra done followed the ignored start");
         tb_errors++;
      end
      if ({product_hi, product_lo} !== ref_product(8'd23, 8'd171)) begin
         $display("FAIL start_while_busy: expected 16'h%04h, actual 16'h%04h",
                  ref_product(8'd23, 8'd171), {product_hi, product_lo});
         tb_errors++;
      end
      finish_test("start_while_busy", errs_before);
   endtask

   task automatic test_back_to_back();
      int errs_before;
      int target;
      errs_before = total_errors();
      target      = checked_count + 2;
      launch_product("back-to-back first", 8'd77, 8'd201);
      // the next drive lands on the last step edge, so start is seen in the done cycle.
      repeat (step_count - 1) @(posedge clk);
      launch_product("back-to-back second", 8'd255, 8'd3);
      @(negedge clk);
      if (!busy) begin
         $display("ERROR: back_to_back: start in the done cycle was not accepted");
         tb_errors++;
      end
      wait_checked(target, "back-to-back");
      finish_test("back_to_back", errs_before);
   endtask

   task automatic test_latency();
      int   errs_before;
      int   target;
      int   edges;
      logic got;
      errs_before = total_errors();
      target      = checked_count + 1;
      exp_q.push_back(ref_product(8'd13, 8'd19));
      name_q.push_back("latency 13x19");
      @(posedge clk);
      start        <= 1'b1;
      multiplier   <= 8'd13;
      multiplicand <= 8'd19;
      edges = 0;
      got   = 1'b0;
      while (!got && edges < wait_limit) begin
         @(posedge clk);
         start <= 1'b0;
         edges++;
         @(negedge clk);
         got = done;
      end
      if (!got) begin
         $display("ERROR: latency: done never arrived within %0d cycles", wait_limit);
         tb_errors++;
      end else begin
         if (edges != done_edges) begin
            $display("FAIL latency: expected %0d edges, actual %0d edges", done_edges, edges);
            tb_errors++;
         end
         if (busy) begin
            $display("ERROR: latency: busy still high when done rose");
            tb_errors++;
         end
      end
      wait_checked(target, "latency 13x19");
      finish_test("latency", errs_before);
   endtask

   task automatic test_reset_mid_product();
      int errs_before;
      int dones_before;
      errs_before = total_errors();
      launch_product("aborted", 8'd99, 8'd250);
      repeat (3) @(posedge clk);
      rst_n <= 1'b0;
      // the aborted product never reaches the comparator.
      void'(exp_q.pop_back());
      void'(name_q.pop_back());
      dones_before = checked_count;
      @(posedge clk);
      @(negedge clk);
      check_idle_zero("reset_mid_product");
      @(posedge clk);
      rst_n <= 1'b1;
      repeat (2 * done_edges) @(negedge clk);
      if (checked_count != dones_before) begin
         $display("ERROR: reset_mid_product: done appeared for the aborted product");
         tb_errors++;
      end
      run_product("after reset 201x37", 8'd201, 8'd37);
      finish_test("reset_mid_product", errs_before);
   endtask

   initial begin
      start        = 1'b0;
      multiplier   = '0;
      multiplicand = '0;
      rst_n        = 1'b0;
      void'($urandom(32'h2437c093));

      test_reset_state();
      test_corner_values();
      test_random_operands();
      test_start_while_busy();
      test_back_to_back();
      test_latency();
      test_reset_mid_product();

      $display("tests %0d, failed %0d, products checked %0d, errors %0d",
               test_count, failed_tests, check_count, total_errors());
      if (failed_tests == 0 && total_errors() == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: dv/mult_8_assert.sv
`timescale 1ns/1ps

module mult_8_assert (
   input logic clk,
   input logic rst_n,
   input logic start,
   input logic busy,
   input logic done
);

   // done is a single-cycle pulse.
   done_one_cycle: assert property (
      @(posedge clk) disable iff (!rst_n)
      done |=> !done
   ) else $error("done stayed high for more than one cycle");

   // done only shows up right after busy dropped.
   done_after_busy: assert property (
      @(posedge clk) disable iff (!rst_n)
      done |-> (!busy && $past(busy))
   ) else $error("done was high without busy having just fallen");

   // an accepted start produces done nine sampled edges later.
   accept_to_done: assert property (
      @(posedge clk) disable iff (!rst_n)
      (start && !busy) |-> ##9 done
   ) else $error("done did not follow an accepted start after nine edges");

endmodule

bind mult_8 mult_8_assert u_assert (
   .clk   (clk),
   .rst_n (rst_n),
   .start (start),
   .busy  (busy),
   .done  (done)
);

// File: verilog/mult_8.sv
`timescale 1ns/1ps

module mult_8
   import mult_types_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     start,
   input  operand_t multiplier,
   input  operand_t multiplicand,
   output logic     busy,
   output logic     done,
   output operand_t product_lo,
   output operand_t product_hi
);

   logic     clear;
   logic     step;
   logic     last;
   logic     cur_bit;
   bit_idx_t bit_idx;
   operand_t multiplicand_q;
   logic     low_bit;
   operand_t next_acc;

   mult_bit_sequencer u_seq (
      .clk            (clk),
      .rst_n          (rst_n),
      .start          (start),
      .multiplier     (multiplier),
      .multiplicand   (multiplicand),
      .busy           (busy),
      .clear          (clear),
      .step           (step),
      .last           (last),
      .cur_bit        (cur_bit),
      .bit_idx        (bit_idx),
      .multiplicand_q (multiplicand_q)
   );

   mult_add_shift u_add_shift (
      .clk            (clk),
      .rst_n          (rst_n),
      .clear          (clear),
      .step           (step),
      .cur_bit        (cur_bit),
      .multiplicand_q (multiplicand_q),
      .low_bit        (low_bit),
      .next_acc       (next_acc)
   );

   mult_product_assembler u_asm (
      .clk        (clk),
      .rst_n      (rst_n),
      .step       (step),
      .last       (last),
      .bit_idx    (bit_idx),
      .low_bit    (low_bit),
      .next_acc   (next_acc),
      .product_lo (product_lo),
      .product_hi (product_hi),
      .done       (done)
   );

endmodule

// File: verilog/mult_product_assembler.sv
`timescale 1ns/1ps

module mult_product_assembler
   import mult_types_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     step,
   input  logic     last,
   input  bit_idx_t bit_idx,
   input  logic     low_bit,
   input  operand_t next_acc,
   output operand_t product_lo,
   output operand_t product_hi,
   output logic     done
);

   // bits shifted out so far are stored by position.
   operand_t low_q;

   // low byte with the current bit already in place.
   operand_t low_next;

   always_comb begin
      low_next          = low_q;
      low_next[bit_idx] = low_bit;
   end

   always_ff @(posedge clk) begin
      if (step) begin
         low_q <= low_next;
      end
   end

   // both halves are taken on the edge of the final step.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         product_lo <= '0;
         product_hi <= '0;
      end else if (step && last) begin
         product_lo <= low_next;
         product_hi <= next_acc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         done <= 1'b0;
      end else begin
         done <= step && last;
      end
   end

endmodule

// File: verilog/mult_add_shift.sv
`timescale 1ns/1ps

module mult_add_shift
   import mult_cfg_pkg::*;
   import mult_types_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     clear,
   input  logic     step,
   input  logic     cur_bit,
   input  operand_t multiplicand_q,
   output logic     low_bit,
   output operand_t next_acc
);

   // running high byte of the partial product.
   operand_t acc;

   // multiplicand or zero, picked by the current multiplier bit.
   operand_t addend;

   // one extra bit so the carry survives the add.
   logic [op_width:0] sum;

   assign addend = cur_bit ? multiplicand_q : '0;

   always_comb begin
      sum = {1'b0, acc} + {1'b0, addend};
   end

   // halving moves the carry into the msb and drops bit 0.
   assign next_acc = sum[op_width:1];
   assign low_bit  = sum[0];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (clear) begin
         acc <= '0;
      end else if (step) begin
         acc <= next_acc;
      end
   end

endmodule

// File: verilog/mult_bit_sequencer.sv
`timescale 1ns/1ps

module mult_bit_sequencer
   import mult_cfg_pkg::*;
   import mult_types_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     start,
   input  operand_t multiplier,
   input  operand_t multiplicand,
   output logic     busy,
   output logic     clear,
   output logic     step,
   output logic     last,
   output logic     cur_bit,
   output bit_idx_t bit_idx,
   output operand_t multiplicand_q
);

   seq_state_t state;
   seq_state_t state_next;
   bit_idx_t   cnt;
   operand_t   multiplier_q;
   logic       accept;
   logic       at_last;

   // start only counts while idle.
   assign accept  = start && (state == seq_idle);
   assign at_last = (cnt == bit_idx_t'(last_idx));

   always_comb begin
      state_next = state;
      case (state)
         seq_idle: begin
            if (accept) begin
               state_next = seq_run;
            end
         end
         seq_run: begin
            // the last step hands back to idle on the same edge.
            if (at_last) begin
               state_next = seq_idle;
            end
         end
         default: begin
            state_next = seq_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= seq_idle;
      end else begin
         state <= state_next;
      end
   end

   // the bit counter walks 0 to 7 while running.
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (accept) begin
         cnt <= '0;
      end else if (state == seq_run) begin
         cnt <= cnt + 1'b1;
      end
   end

   // operands are held for the whole product.
   always_ff @(posedge clk) begin
      if (accept) begin
         multiplier_q   <= multiplier;
         multiplicand_q <= multiplicand;
      end
   end

   assign busy  = (state == seq_run);
   assign step  = (state == seq_run);
   assign clear = accept;
   assign last  = step && at_last;

   // select the multiplier bit for this step.
   assign cur_bit = multiplier_q[cnt];
   assign bit_idx = cnt;

endmodule

// File: verilog/mult_types_pkg.sv
package mult_types_pkg;

   import mult_cfg_pkg::*;

   // one operand byte that also serves as the partial product and each product half.
   typedef logic [op_width-1:0] operand_t;

   // position of a multiplier bit.
   typedef logic [idx_width-1:0] bit_idx_t;

   // sequencer states.
   typedef enum logic [0:0] {
      seq_idle = 1'b0,
      seq_run  = 1'b1
   } seq_state_t;

endpackage

// File: verilog/mult_cfg_pkg.sv
package mult_cfg_pkg;

   // operand width in bits.
   localparam int unsigned op_width = 8;

   // one add-shift step per multiplier bit.
   localparam int unsigned step_count = 8;

   // width of the multiplier bit index.
   localparam int unsigned idx_width = 3;

   // index of the final step.
   localparam int unsigned last_idx = step_count - 1;

endpackage
